// ==== Bender.yml ====
package:
  name: memctl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mcl_pkg.sv
      - rtl/memCtlIf.sv
      - rtl/memFuncDecode.sv
      - rtl/vmaContext.sv
      - rtl/heldFlags.sv
      - rtl/diagReadout.sv
      - rtl/memCtlTop.sv
      - target: test
        files:
          - verif/memCtl_assert.sv
          - verif/memCtl_tb.sv

// ==== compile.f ====
+incdir+rtl
rtl/mcl_pkg.sv
rtl/memCtlIf.sv
rtl/memFuncDecode.sv
rtl/vmaContext.sv
rtl/heldFlags.sv
rtl/diagReadout.sv
rtl/memCtlTop.sv
verif/memCtl_assert.sv
verif/memCtl_tb.sv

// ==== rtl/diagReadout.sv ====
`include "mcl_cfg.svh"

module diagReadout
  import mcl_pkg::*;
(
  input  logic                   diagRead,
  input  diagSelE                diagSel,
  input  logic [`MCL_HELD_W-1:0] heldOrPc,
  memCtlIf.observe               bus,
  output logic [`MCL_DIAG_W-1:0] diagData
);

  always_comb begin
    diagData = '0;
    if (diagRead) begin
      case (diagSel)
        diagHeldLow: begin
          diagData = heldOrPc[5:0];
        end
        diagHeldHigh: begin
          diagData = {2'b00, heldOrPc[9:6]};
        end
        diagReq: begin
          diagData = {bus.adrErr, bus.fetch, bus.write,
                      bus.pause, bus.loadArx, bus.loadAr};
        end
        diagCtx: begin
          diagData = {2'b00, bus.vmaExtended, bus.vmaPrevious,
                      bus.vmaPublic, bus.vmaUser};
        end
        // Unused groups float low on the EBUS
        default: begin
          diagData = '0;
        end
      endcase
    end
  end

endmodule

// ==== rtl/heldFlags.sv ====
`include "mcl_cfg.svh"

module heldFlags (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   loadVmaHeld,
  input  logic                   condSelVma,
  input  logic [`MCL_HELD_W-1:0] pcFlags,
  memCtlIf.observe               bus,
  output logic [`MCL_HELD_W-1:0] heldOrPc
);

  logic [`MCL_HELD_W-1:0] snapshot;
  logic [`MCL_HELD_W-1:0] heldReg;

  // loadAr sits in bit 0, adrErr in bit 9
  assign snapshot = {bus.adrErr,
                     bus.fetch,
                     bus.vmaExtended,
                     bus.vmaPrevious,
                     bus.vmaPublic,
                     bus.vmaUser,
                     bus.write,
                     bus.pause,
                     bus.loadArx,
                     bus.loadAr};

  always_ff @(posedge clk) begin
    if (!rstN) begin
      heldReg <= '0;
    end else if (loadVmaHeld) begin
      heldReg <= snapshot;
    end
  end

  // Conditional dispatch tests VMA state or PC flags
  assign heldOrPc = condSelVma ? heldReg : pcFlags;

endmodule

// ==== rtl/mcl_cfg.svh ====
`ifndef MCL_CFG_SVH
`define MCL_CFG_SVH

// Extended address slice checked at VMA load, bits 12..0
`define MCL_AD_W 13

// Held snapshot and PC flags
`define MCL_HELD_W 10

// Diagnostic bus slice driven by this board
`define MCL_DIAG_W 6

`endif

// ==== rtl/mcl_pkg.sv ====
package mcl_pkg;

  // Microcode memory function, qualified by DRAM A for Aread
  typedef enum logic [2:0] {
    memNop      = 3'd0,
    memAread    = 3'd1,
    memWrite    = 3'd2,
    memRwCycle  = 3'd3,
    memRpwCycle = 3'd4,
    memLoadAr   = 3'd5,
    memLoadArx  = 3'd6,
    memFetch    = 3'd7
  } memFuncE;

  // Diagnostic readback groups
  // Codes 4..7 read back as zero
  typedef enum logic [2:0] {
    diagHeldLow  = 3'd0,
    diagHeldHigh = 3'd1,
    diagReq      = 3'd2,
    diagCtx      = 3'd3
  } diagSelE;

endpackage

// ==== rtl/memCtlIf.sv ====
interface memCtlIf;

  // Registered request flags
  logic loadAr;
  logic loadArx;
  logic pause;
  logic write;
  logic fetch;

  // Registered VMA context
  logic vmaUser;
  logic vmaPublic;
  logic vmaPrevious;
  logic vmaExtended;
  logic adrErr;

  modport decode(output loadAr, loadArx, pause, write, fetch);

  modport ctx(output vmaUser, vmaPublic, vmaPrevious, vmaExtended, adrErr);

  modport observe(input loadAr, loadArx, pause, write, fetch,
                  input vmaUser, vmaPublic, vmaPrevious, vmaExtended, adrErr);

endinterface

// ==== rtl/memCtlTop.sv ====
`include "mcl_cfg.svh"

module memCtlTop
  import mcl_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   memReq,
  input  memFuncE                memFunc,
  input  logic [2:0]             dramA,
  input  logic [8:0]             magic,
  input  logic                   userMode,
  input  logic                   publicMode,
  input  logic                   prevEn,
  input  logic [`MCL_AD_W-1:0]   adField,
  input  logic                   loadVmaHeld,
  input  logic                   condSelVma,
  input  logic [`MCL_HELD_W-1:0] pcFlags,
  input  logic                   diagRead,
  input  diagSelE                diagSel,
  output logic                   cycReq,
  output logic                   loadAr,
  output logic                   loadArx,
  output logic                   vmaPause,
  output logic                   vmaWrite,
  output logic                   vmaFetch,
  output logic                   vmaUser,
  output logic                   vmaPublic,
  output logic                   vmaPrevious,
  output logic                   vmaExtended,
  output logic                   vmaAdrErr,
  output logic [`MCL_HELD_W-1:0] heldOrPc,
  output logic [`MCL_DIAG_W-1:0] diagData
);

  memCtlIf bus();

  memFuncDecode u_decode (
    .clk     (clk),
    .rstN    (rstN),
    .memReq  (memReq),
    .memFunc (memFunc),
    .dramA   (dramA),
    .cycReq  (cycReq),
    .bus     (bus.decode)
  );

  vmaContext u_context (
    .clk        (clk),
    .rstN       (rstN),
    .memReq     (memReq),
    .memFunc    (memFunc),
    .magic      (magic),
    .userMode   (userMode),
    .publicMode (publicMode),
    .prevEn     (prevEn),
    .adField    (adField),
    .bus        (bus.ctx)
  );

  heldFlags u_held (
    .clk         (clk),
    .rstN        (rstN),
    .loadVmaHeld (loadVmaHeld),
    .condSelVma  (condSelVma),
    .pcFlags     (pcFlags),
    .bus         (bus.observe),
    .heldOrPc    (heldOrPc)
  );

  diagReadout u_diag (
    .diagRead (diagRead),
    .diagSel  (diagSel),
    .heldOrPc (heldOrPc),
    .bus      (bus.observe),
    .diagData (diagData)
  );

  // Status out to the MBOX side
  assign loadAr      = bus.loadAr;
  assign loadArx     = bus.loadArx;
  assign vmaPause    = bus.pause;
  assign vmaWrite    = bus.write;
  assign vmaFetch    = bus.fetch;
  assign vmaUser     = bus.vmaUser;
  assign vmaPublic   = bus.vmaPublic;
  assign vmaPrevious = bus.vmaPrevious;
  assign vmaExtended = bus.vmaExtended;
  assign vmaAdrErr   = bus.adrErr;

endmodule

// ==== rtl/memFuncDecode.sv ====
module memFuncDecode
  import mcl_pkg::*;
(
  input  logic    clk,
  input  logic    rstN,
  input  logic    memReq,
  input  memFuncE memFunc,
  input  logic [2:0] dramA,
  output logic    cycReq,
  memCtlIf.decode bus
);

  logic isAread;
  logic areadA1;
  logic areadA7;
  logic areadA367;
  logic loadArNext;
  logic loadArxNext;
  logic pauseNext;
  logic writeNext;
  logic fetchNext;

  always_comb begin
    isAread   = (memFunc == memAread);
    areadA1   = isAread && (dramA == 3'd1);
    areadA7   = isAread && (dramA == 3'd7);
    // A = 3, 6 or 7 writes back the result
    areadA367 = isAread && ((dramA == 3'd3) || (dramA == 3'd6) || (dramA == 3'd7));

    loadArNext  = (memFunc == memLoadAr) || (memFunc == memRwCycle) ||
                  (memFunc == memRpwCycle) || (isAread && dramA[2]);
    loadArxNext = (memFunc == memLoadArx) || (memFunc == memFetch) || areadA1;
    pauseNext   = (memFunc == memRpwCycle) || areadA7;
    writeNext   = (memFunc == memWrite) || (memFunc == memRwCycle) ||
                  (memFunc == memRpwCycle) || areadA367;
    fetchNext   = (memFunc == memFetch) || areadA1;
  end

  assign cycReq = memReq && (memFunc != memNop);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      bus.loadAr  <= 1'b0;
      bus.loadArx <= 1'b0;
      bus.pause   <= 1'b0;
      bus.write   <= 1'b0;
      bus.fetch   <= 1'b0;
    end else if (memReq) begin
      bus.loadAr  <= loadArNext;
      bus.loadArx <= loadArxNext;
      bus.pause   <= pauseNext;
      bus.write   <= writeNext;
      bus.fetch   <= fetchNext;
    end
  end

endmodule

// ==== rtl/vmaContext.sv ====
`include "mcl_cfg.svh"

module vmaContext
  import mcl_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 memReq,
  input  memFuncE              memFunc,
  input  logic [8:0]           magic,
  input  logic                 userMode,
  input  logic                 publicMode,
  input  logic                 prevEn,
  input  logic [`MCL_AD_W-1:0] adField,
  memCtlIf.ctx                 bus
);

  logic extEn;
  logic adrBad;
  logic adrErrNext;

  always_comb begin
    // Magic bit 7 asks for an extended reference
    extEn  = magic[7];
    // Section bits must be clear and bit 12 set for a legal extended address
    adrBad = (adField[11:6] != 6'b0) || !adField[12];
    adrErrNext = extEn && (memFunc != memNop) && adrBad;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      bus.vmaUser     <= 1'b0;
      bus.vmaPublic   <= 1'b0;
      bus.vmaPrevious <= 1'b0;
      bus.vmaExtended <= 1'b0;
      bus.adrErr      <= 1'b0;
    end else if (memReq) begin
      bus.vmaUser     <= userMode;
      bus.vmaPublic   <= publicMode;
      bus.vmaPrevious <= prevEn;
      bus.vmaExtended <= extEn;
      bus.adrErr      <= adrErrNext;
    end
  end

endmodule

// ==== verif/memCtl_assert.sv ====
module memCtl_assert (
  input logic clk,
  input logic rstN,
  input logic loadAr,
  input logic loadArx,
  input logic pause,
  input logic write,
  input logic vmaExtended,
  input logic adrErr
);

  timeunit 1ns;
  timeprecision 1ps;

  // RPW and Aread A=7 both pause and write
  pauseImpliesWrite: assert property (@(posedge clk) disable iff (!rstN) pause |-> write)
    else $error("pause flag set without write");

  flagsClearAfterReset: assert property (@(posedge clk)
    !rstN |=> !(loadAr || loadArx || pause || write))
    else $error("request flags not cleared by reset");

  adrErrNeedsExtended: assert property (@(posedge clk) disable iff (!rstN)
    adrErr |-> vmaExtended)
    else $error("address error without extended reference");

endmodule

bind memFuncDecode memCtl_assert u_decodeAssert (
  .clk(clk), .rstN(rstN), .loadAr(bus.loadAr), .loadArx(bus.loadArx),
  .pause(bus.pause), .write(bus.write), .vmaExtended(1'b0), .adrErr(1'b0)
);

bind vmaContext memCtl_assert u_contextAssert (
  .clk(clk), .rstN(rstN), .loadAr(1'b0), .loadArx(1'b0), .pause(1'b0),
  .write(1'b0), .vmaExtended(bus.vmaExtended), .adrErr(bus.adrErr)
);

// ==== verif/memCtl_tb.sv ====
`include "mcl_cfg.svh"

module memCtl_tb
  import mcl_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int numTests    = 400;
  // Reset, directed sweep, error cases, random run and drain
  localparam int totalCycles = 10 + 64 + 8 + numTests + 4;
  localparam int watchdogNs  = totalCycles * 10 + 500;

  logic                   clk = 1'b0;
  logic                   rstN;
  logic                   memReq;
  memFuncE                memFunc;
  logic [2:0]             dramA;
  logic [8:0]             magic;
  logic                   userMode;
  logic                   publicMode;
  logic                   prevEn;
  logic [`MCL_AD_W-1:0]   adField;
  logic                   loadVmaHeld;
  logic                   condSelVma;
  logic [`MCL_HELD_W-1:0] pcFlags;
  logic                   diagRead;
  diagSelE                diagSel;
  logic                   cycReq;
  logic                   loadAr;
  logic                   loadArx;
  logic                   vmaPause;
  logic                   vmaWrite;
  logic                   vmaFetch;
  logic                   vmaUser;
  logic                   vmaPublic;
  logic                   vmaPrevious;
  logic                   vmaExtended;
  logic                   vmaAdrErr;
  logic [`MCL_HELD_W-1:0] heldOrPc;
  logic [`MCL_DIAG_W-1:0] diagData;

  // Mirror state in the held register bit order
  logic [`MCL_HELD_W-1:0] vmaModel;
  logic [`MCL_HELD_W-1:0] heldModel;
  logic [`MCL_HELD_W-1:0] expHeldOrPc;
  logic [`MCL_DIAG_W-1:0] expDiag;
  logic                   checkEn = 1'b0;
  integer                 seed;
  int                     errorCount = 0;
  int                     checkCount = 0;
  int                     fIdx;
  int                     aIdx;

  always #5 clk = ~clk;

  memCtlTop u_dut (
    .clk         (clk),
    .rstN        (rstN),
    .memReq      (memReq),
    .memFunc     (memFunc),
    .dramA       (dramA),
    .magic       (magic),
    .userMode    (userMode),
    .publicMode  (publicMode),
    .prevEn      (prevEn),
    .adField     (adField),
    .loadVmaHeld (loadVmaHeld),
    .condSelVma  (condSelVma),
    .pcFlags     (pcFlags),
    .diagRead    (diagRead),
    .diagSel     (diagSel),
    .cycReq      (cycReq),
    .loadAr      (loadAr),
    .loadArx     (loadArx),
    .vmaPause    (vmaPause),
    .vmaWrite    (vmaWrite),
    .vmaFetch    (vmaFetch),
    .vmaUser     (vmaUser),
    .vmaPublic   (vmaPublic),
    .vmaPrevious (vmaPrevious),
    .vmaExtended (vmaExtended),
    .vmaAdrErr   (vmaAdrErr),
    .heldOrPc    (heldOrPc),
    .diagData    (diagData)
  );

  // {adrErr, fetch, ext, prev, public, user, write, pause, loadArx, loadAr}
  function automatic logic [`MCL_HELD_W-1:0] refFlags(
    input memFuncE f, input logic [2:0] a, input logic [8:0] mg,
    input logic [`MCL_AD_W-1:0] ad, input logic usr, input logic pub, input logic prev);
    logic ldAr;
    logic ldArx;
    logic ps;
    logic wr;
    logic fe;
    logic err;
    ldAr  = 1'b0;
    ldArx = 1'b0;
    ps    = 1'b0;
    wr    = 1'b0;
    fe    = 1'b0;
    case (f)
      memAread: begin
        ldAr  = a[2];
        ldArx = (a == 3'd1);
        fe    = (a == 3'd1);
        ps    = (a == 3'd7);
        wr    = (a == 3'd3) || (a == 3'd6) || (a == 3'd7);
      end
      memWrite:    wr = 1'b1;
      memRwCycle:  {ldAr, wr} = 2'b11;
      memRpwCycle: {ldAr, ps, wr} = 3'b111;
      memLoadAr:   ldAr = 1'b1;
      memLoadArx:  ldArx = 1'b1;
      memFetch:    {ldArx, fe} = 2'b11;
      default:     ldAr = 1'b0;
    endcase
    err = mg[7] && (f != memNop) && ((ad[11:6] != 6'b0) || !ad[12]);
    return {err, fe, mg[7], prev, pub, usr, wr, ps, ldArx, ldAr};
  endfunction

  function automatic logic [`MCL_DIAG_W-1:0] diagRef(
    input logic rd, input diagSelE sel, input logic [`MCL_HELD_W-1:0] held,
    input logic [`MCL_HELD_W-1:0] st);
    if (!rd) return '0;
    case (sel)
      diagHeldLow:  return held[5:0];
      diagHeldHigh: return {2'b00, held[9:6]};
      diagReq:      return {st[9], st[8], st[3], st[2], st[1], st[0]};
      diagCtx:      return {2'b00, st[7:4]};
      default:      return '0;
    endcase
  endfunction

  task automatic checkVal(input string name, input logic [9:0] exp, input logic [9:0] act);
    checkCount++;
    if (act !== exp) begin
      errorCount++;
      $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    end
  endtask

  task automatic driveReq(input logic req, input memFuncE f, input logic [2:0] a,
                          input logic [8:0] mg, input logic [`MCL_AD_W-1:0] ad);
    @(posedge clk);
    memReq  <= req;
    memFunc <= f;
    dramA   <= a;
    magic   <= mg;
    adField <= ad;
  endtask

  task automatic driveRandom();
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = $random(seed);
    r2 = $random(seed);
    @(posedge clk);
    memReq      <= r1[0];
    memFunc     <= memFuncE'(r1[3:1]);
    dramA       <= r1[6:4];
    magic       <= r1[15:7];
    userMode    <= r1[16];
    publicMode  <= r1[17];
    prevEn      <= r1[18];
    loadVmaHeld <= (r1[20:19] == 2'b00);
    condSelVma  <= r1[21];
    diagRead    <= (r1[23:22] != 2'b00);
    diagSel     <= diagSelE'(r1[26:24]);
    // Legal extended addresses about half the time
    adField     <= r1[27] ? {1'b1, 6'b0, r2[5:0]} : r2[12:0];
    pcFlags     <= r2[22:13];
  endtask

  // Reference registers
  always @(posedge clk) begin
    if (!rstN) begin
      vmaModel  <= '0;
      heldModel <= '0;
    end else begin
      if (memReq) vmaModel <= refFlags(memFunc, dramA, magic, adField,
                                       userMode, publicMode, prevEn);
      if (loadVmaHeld) heldModel <= vmaModel;
    end
  end

  always @(negedge clk) begin
    if (checkEn) begin
      expHeldOrPc = condSelVma ? heldModel : pcFlags;
      expDiag     = diagRef(diagRead, diagSel, expHeldOrPc, vmaModel);
      checkVal("cycReq", memReq && (memFunc != memNop), cycReq);
      checkVal("loadAr", vmaModel[0], loadAr);
      checkVal("loadArx", vmaModel[1], loadArx);
      checkVal("vmaPause", vmaModel[2], vmaPause);
      checkVal("vmaWrite", vmaModel[3], vmaWrite);
      checkVal("vmaUser", vmaModel[4], vmaUser);
      checkVal("vmaPublic", vmaModel[5], vmaPublic);
      checkVal("vmaPrevious", vmaModel[6], vmaPrevious);
      checkVal("vmaExtended", vmaModel[7], vmaExtended);
      checkVal("vmaFetch", vmaModel[8], vmaFetch);
      checkVal("vmaAdrErr", vmaModel[9], vmaAdrErr);
      checkVal("heldOrPc", expHeldOrPc, heldOrPc);
      checkVal("diagData", expDiag, diagData);
    end
  end

  initial begin
    seed        = 32'heeca_8ec8;
    rstN        <= 1'b0;
    memReq      <= 1'b0;
    memFunc     <= memNop;
    dramA       <= 3'd0;
    magic       <= 9'd0;
    userMode    <= 1'b0;
    publicMode  <= 1'b0;
    prevEn      <= 1'b0;
    adField     <= '0;
    loadVmaHeld <= 1'b0;
    condSelVma  <= 1'b0;
    pcFlags     <= '0;
    diagRead    <= 1'b0;
    diagSel     <= diagHeldLow;
    repeat (10) @(posedge clk);
    rstN    <= 1'b1;
    checkEn <= 1'b1;
    @(posedge clk);
    diagRead   <= 1'b1;
    diagSel    <= diagReq;
    // Held register shows its reset value against nonzero PC flags
    condSelVma <= 1'b1;
    pcFlags    <= 10'h2a5;
    // Every function and every A field under Aread
    for (fIdx = 0; fIdx < 8; fIdx++) begin
      for (aIdx = 0; aIdx < 8; aIdx++) begin
        if (fIdx == memAread || aIdx == 0) begin
          driveReq(1'b1, memFuncE'(fIdx), aIdx[2:0], 9'h000, 13'h1000);
        end
      end
    end
    driveReq(1'b0, memRpwCycle, 3'd7, 9'h080, 13'h0000);
    // Extended address error cases
    driveReq(1'b1, memWrite, 3'd0, 9'h080, 13'h1000);
    driveReq(1'b1, memWrite, 3'd0, 9'h080, 13'h1040);
    driveReq(1'b1, memLoadAr, 3'd0, 9'h080, 13'h0005);
    driveReq(1'b1, memNop, 3'd0, 9'h080, 13'h0fc0);
    driveReq(1'b0, memNop, 3'd0, 9'h000, 13'h0000);
    for (fIdx = 0; fIdx < numTests; fIdx++) begin
      driveRandom();
    end
    repeat (2) @(posedge clk);
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("Timeout: stimulus did not complete within %0d ns", watchdogNs);
    $display("Done: errors found");
    $finish;
  end

endmodule
